//--- fetch_cfg_pkg.sv
package fetch_cfg_pkg;

  // ------------------------------------------------------------------
  // cache geometry
  // ------------------------------------------------------------------

  // byte offset within a 16 byte line
  localparam int offset_bits = 4;
  localparam int index_bits = 2;
  localparam int line_count = 4;
  localparam int tag_bits = 32 - index_bits - offset_bits;
  localparam int words_per_line = 4;
  localparam int line_bits = words_per_line * 32;

  // ------------------------------------------------------------------
  // address map
  // ------------------------------------------------------------------

  localparam logic [31:0] reset_pc = 32'h3000_0000;

  // top byte of the region that bypasses the cache
  localparam logic [7:0] uncached_top = 8'h0f;

  function automatic logic is_uncached(input logic [31:0] addr);
    return addr[31 -: 8] == uncached_top;
  endfunction

  // ------------------------------------------------------------------
  // fetch side types
  // ------------------------------------------------------------------

  // flat view for the refill shift, word view for the hit path
  typedef union packed {
    logic [line_bits-1:0] flat;
    logic [words_per_line-1:0][31:0] words;
  } cache_line_u;

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
  } fetch_out_t;

  typedef struct packed {
    logic npc_valid;
    logic [31:0] npc;
    logic [31:0] snpc;
  } commit_fb_t;

  typedef struct packed {
    logic hit;
    logic [31:0] word;
  } lookup_t;

endpackage

//--- axi_rd_pkg.sv
package axi_rd_pkg;

  // ------------------------------------------------------------------
  // read address channel
  // ------------------------------------------------------------------

  typedef struct packed {
    logic [31:0] araddr;
    logic [7:0] arlen;
  } ar_chan_t;

  // ------------------------------------------------------------------
  // read data channel
  // ------------------------------------------------------------------

  // rresp travels with the beat but nothing acts on it yet
  typedef struct packed {
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rlast;
  } r_chan_t;

  // ------------------------------------------------------------------
  // burst lengths encoded as beats minus one
  // ------------------------------------------------------------------

  // four beats fill one line
  localparam logic [7:0] line_burst_len = 8'd3;

  // one beat for an uncached word
  localparam logic [7:0] single_burst_len = 8'd0;

endpackage

//--- icache_store.sv
`timescale 1ns/1ns

module icache_store (
  input  logic clock,
  input  logic reset,

  input  logic [31:0] lookup_pc,
  output fetch_cfg_pkg::lookup_t lookup,

  input  logic fill_en,
  input  logic [31:0] fill_pc,
  input  fetch_cfg_pkg::cache_line_u fill_line,

  input  logic clear_cache
);

  localparam int off_w = fetch_cfg_pkg::offset_bits;
  localparam int idx_w = fetch_cfg_pkg::index_bits;
  localparam int tag_w = fetch_cfg_pkg::tag_bits;
  localparam int lines = fetch_cfg_pkg::line_count;

  logic valid_q [lines];
  logic [tag_w-1:0] tag_q [lines];
  fetch_cfg_pkg::cache_line_u data_q [lines];

  logic [idx_w-1:0] rd_index;
  logic [tag_w-1:0] rd_tag;
  logic [off_w-3:0] rd_word;
  logic [idx_w-1:0] wr_index;
  logic [tag_w-1:0] wr_tag;

  assign rd_index = lookup_pc[off_w +: idx_w];
  assign rd_tag = lookup_pc[31 -: tag_w];
  assign rd_word = lookup_pc[off_w-1:2];
  assign wr_index = fill_pc[off_w +: idx_w];
  assign wr_tag = fill_pc[31 -: tag_w];

  // ------------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------------

  // the uncached region never reports a hit
  always_comb begin
    lookup.hit = valid_q[rd_index] && (tag_q[rd_index] == rd_tag) &&
                 !fetch_cfg_pkg::is_uncached(lookup_pc);
    lookup.word = data_q[rd_index].words[rd_word];
  end

  // ------------------------------------------------------------------
  // fill and invalidate
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < lines; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      if (fill_en) begin
        valid_q[wr_index] <= 1'b1;
      end
      // invalidate-all overrides a fill on the same edge
      if (clear_cache) begin
        for (int i = 0; i < lines; i++) begin
          valid_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_en) begin
      tag_q[wr_index] <= wr_tag;
      data_q[wr_index] <= fill_line;
    end
  end

endmodule

//--- line_refill.sv
`timescale 1ns/1ns

module line_refill (
  input  logic clock,
  input  logic reset,

  input  logic refill_start,
  input  logic [31:0] refill_pc,
  input  logic refill_uncached,
  output logic refill_done,
  output fetch_cfg_pkg::cache_line_u refill_line,

  output logic arvalid,
  output axi_rd_pkg::ar_chan_t ar,
  input  logic arready,

  input  logic rvalid,
  input  axi_rd_pkg::r_chan_t r,
  output logic rready
);

  localparam int off_w = fetch_cfg_pkg::offset_bits;
  localparam int line_w = fetch_cfg_pkg::line_bits;

  logic busy;
  logic single_q;
  logic [off_w-3:0] slot_q;
  logic beat;

  // arvalid marks the address phase, rready the data phase
  assign busy = arvalid || rready;
  assign beat = rvalid && rready;

  // ------------------------------------------------------------------
  // handshake control
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid <= 1'b0;
      rready <= 1'b0;
      refill_done <= 1'b0;
    end else begin
      refill_done <= 1'b0;
      if (refill_start && !busy) begin
        arvalid <= 1'b1;
      end
      if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready <= 1'b1;
      end
      if (beat && r.rlast) begin
        rready <= 1'b0;
        refill_done <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // address and line assembly
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (refill_start && !busy) begin
      single_q <= refill_uncached;
      slot_q <= refill_pc[off_w-1:2];
      if (refill_uncached) begin
        ar.araddr <= {refill_pc[31:2], 2'b00};
        ar.arlen <= axi_rd_pkg::single_burst_len;
      end else begin
        ar.araddr <= {refill_pc[31:off_w], {off_w{1'b0}}};
        ar.arlen <= axi_rd_pkg::line_burst_len;
      end
    end
    if (beat) begin
      if (single_q) begin
        refill_line.words[slot_q] <= r.rdata;
      end else begin
        // shift in from the top so the first beat ends in word 0
        refill_line.flat <= {r.rdata, refill_line.flat[line_w-1:32]};
      end
    end
  end

endmodule

//--- fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
  input  logic clock,
  input  logic reset,

  input  fetch_cfg_pkg::commit_fb_t commit,
  input  logic clear_pipeline,

  input  logic idu_ready,
  input  logic block,
  output logic inst_valid,
  output fetch_cfg_pkg::fetch_out_t fetch,

  output logic [31:0] lookup_pc,
  input  fetch_cfg_pkg::lookup_t lookup,

  output logic refill_start,
  output logic refill_uncached,
  input  logic refill_done,
  input  fetch_cfg_pkg::cache_line_u refill_line,

  output logic fill_en,
  output fetch_cfg_pkg::cache_line_u fill_line
);

  localparam int off_w = fetch_cfg_pkg::offset_bits;

  logic [31:0] pc;
  logic [31:0] miss_pc;
  logic refilling;
  logic miss_uncached;
  logic refill_dropped;
  logic pipeline_empty;
  logic path_ok;

  logic go;
  logic commit_match;
  logic on_path;
  logic deliver_hit;
  logic deliver_unc;

  // ------------------------------------------------------------------
  // decisions for this cycle
  // ------------------------------------------------------------------

  // decode takes the output register, or it is empty and may load
  assign go = idu_ready && !block;
  assign commit_match = commit.npc_valid && (commit.snpc == pc);

  // a miss only goes to the bus once the pc is known to be real
  assign on_path = pipeline_empty || path_ok || commit_match;

  assign deliver_hit = !refilling && go && lookup.hit && !clear_pipeline;
  assign refill_start = !refilling && go && !lookup.hit && on_path && !clear_pipeline;
  assign refill_uncached = fetch_cfg_pkg::is_uncached(pc);
  assign deliver_unc = refilling && refill_done && miss_uncached &&
                       !refill_dropped && !clear_pipeline;

  // the fill and refill address stays on the miss while a refill runs
  assign lookup_pc = refilling ? miss_pc : pc;

  assign fill_en = refilling && refill_done && !miss_uncached;
  assign fill_line = refill_line;

  // ------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_cfg_pkg::reset_pc;
      refilling <= 1'b0;
      miss_uncached <= 1'b0;
      refill_dropped <= 1'b0;
      inst_valid <= 1'b0;
      pipeline_empty <= 1'b1;
      path_ok <= 1'b0;
    end else begin
      // commit confirmation is kept until pc moves
      if (commit_match) begin
        path_ok <= 1'b1;
      end

      if (clear_pipeline) begin
        pc <= commit.npc;
        inst_valid <= 1'b0;
        pipeline_empty <= 1'b1;
        path_ok <= 1'b0;
        if (refilling) begin
          refill_dropped <= 1'b1;
        end
      end else if (deliver_hit || deliver_unc) begin
        pc <= pc + 32'd4;
        inst_valid <= 1'b1;
        pipeline_empty <= 1'b0;
        path_ok <= 1'b0;
      end else if (!refilling && go) begin
        // the old word was taken and nothing replaces it yet
        inst_valid <= 1'b0;
      end

      if (refill_start) begin
        refilling <= 1'b1;
        miss_uncached <= refill_uncached;
        refill_dropped <= 1'b0;
      end else if (refilling && refill_done) begin
        refilling <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------
  // payload
  // ------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (refill_start) begin
      miss_pc <= pc;
    end
    if (deliver_hit) begin
      fetch.inst <= lookup.word;
      fetch.pc <= pc;
    end else if (deliver_unc) begin
      fetch.inst <= refill_line.words[miss_pc[off_w-1:2]];
      fetch.pc <= miss_pc;
    end
  end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
  input  logic clock,
  input  logic reset,

  input  fetch_cfg_pkg::commit_fb_t commit,
  input  logic clear_pipeline,
  input  logic clear_cache,

  input  logic idu_ready,
  input  logic block,
  output logic inst_valid,
  output fetch_cfg_pkg::fetch_out_t fetch,

  output logic arvalid,
  output axi_rd_pkg::ar_chan_t ar,
  input  logic arready,
  input  logic rvalid,
  input  axi_rd_pkg::r_chan_t r,
  output logic rready
);

  logic [31:0] lookup_pc;
  fetch_cfg_pkg::lookup_t lookup;
  logic refill_start;
  logic refill_uncached;
  logic refill_done;
  fetch_cfg_pkg::cache_line_u refill_line;
  logic fill_en;
  fetch_cfg_pkg::cache_line_u fill_line;

  fetch_ctrl u_ctrl (
    .clock           (clock),
    .reset           (reset),
    .commit          (commit),
    .clear_pipeline  (clear_pipeline),
    .idu_ready       (idu_ready),
    .block           (block),
    .inst_valid      (inst_valid),
    .fetch           (fetch),
    .lookup_pc       (lookup_pc),
    .lookup          (lookup),
    .refill_start    (refill_start),
    .refill_uncached (refill_uncached),
    .refill_done     (refill_done),
    .refill_line     (refill_line),
    .fill_en         (fill_en),
    .fill_line       (fill_line)
  );

  // lookup_pc follows the miss address during a refill
  icache_store u_store (
    .clock       (clock),
    .reset       (reset),
    .lookup_pc   (lookup_pc),
    .lookup      (lookup),
    .fill_en     (fill_en),
    .fill_pc     (lookup_pc),
    .fill_line   (fill_line),
    .clear_cache (clear_cache)
  );

  line_refill u_refill (
    .clock           (clock),
    .reset           (reset),
    .refill_start    (refill_start),
    .refill_pc       (lookup_pc),
    .refill_uncached (refill_uncached),
    .refill_done     (refill_done),
    .refill_line     (refill_line),
    .arvalid         (arvalid),
    .ar              (ar),
    .arready         (arready),
    .rvalid          (rvalid),
    .r               (r),
    .rready          (rready)
  );

endmodule

//--- tb_mem_slave.sv
`timescale 1ns/1ns

module tb_mem_slave (
  input  logic clock,
  input  logic reset,
  input  logic arvalid,
  input  axi_rd_pkg::ar_chan_t ar,
  output logic arready,
  output logic rvalid,
  output axi_rd_pkg::r_chan_t r,
  input  logic rready,
  output int line_reads,
  output int word_reads
);

  localparam logic [31:0] mem_key = 32'h5a5a_0000;

  logic [15:0] lfsr;
  logic burst_open;
  logic addr_done;
  logic beat_done;
  logic [31:0] beat_addr;
  int beats_left;

  // galois form stepped once per bit
  function automatic logic random_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ mem_key;
  endfunction

  initial begin
    lfsr = 16'd38;
    arready = 1'b0;
    rvalid = 1'b0;
    r = '0;
    line_reads = 0;
    word_reads = 0;
    burst_open = 1'b0;
    addr_done = 1'b0;
    beat_done = 1'b0;
    beat_addr = '0;
    beats_left = 0;
  end

  // handshakes decided here complete on the next rising edge
  always @(negedge clock) begin
    if (reset) begin
      arready = 1'b0;
      rvalid = 1'b0;
      burst_open = 1'b0;
      addr_done = 1'b0;
      beat_done = 1'b0;
    end else begin
      // ------------------------------------------------------------------
      // read data channel
      // ------------------------------------------------------------------
      if (beat_done) begin
        rvalid = 1'b0;
        beat_done = 1'b0;
        beat_addr = beat_addr + 32'd4;
        beats_left--;
        if (beats_left == 0) begin
          burst_open = 1'b0;
        end
      end
      if (burst_open && rready && !rvalid) begin
        if (random_bit()) begin
          rvalid = 1'b1;
          r.rdata = mem_word(beat_addr);
          r.rresp = 2'b00;
          r.rlast = (beats_left == 1);
        end
      end
      if (rvalid && rready) begin
        beat_done = 1'b1;
      end

      // ------------------------------------------------------------------
      // read address channel
      // ------------------------------------------------------------------
      if (addr_done) begin
        arready = 1'b0;
        addr_done = 1'b0;
      end
      if (!burst_open && arvalid && !arready) begin
        if (random_bit()) begin
          arready = 1'b1;
        end
      end
      if (arvalid && arready) begin
        burst_open = 1'b1;
        addr_done = 1'b1;
        beat_addr = ar.araddr;
        beats_left = ar.arlen + 1;
        if (ar.arlen == axi_rd_pkg::line_burst_len) begin
          line_reads++;
        end else if (ar.arlen == axi_rd_pkg::single_burst_len) begin
          word_reads++;
        end
      end
    end
  end

endmodule

//--- tb_fetch_top.sv
`timescale 1ns/1ns

module tb_fetch_top;

  localparam logic [31:0] mem_key = 32'h5a5a_0000;
  localparam int row_count = 10;

  typedef struct packed {
    logic [31:0] target;
    logic [7:0] count;
    logic random_stall;
    logic flush;
    logic [7:0] reads;
  } row_t;

  logic clock;
  logic reset;
  fetch_cfg_pkg::commit_fb_t commit;
  logic clear_pipeline;
  logic clear_cache;
  logic idu_ready;
  logic block;
  logic inst_valid;
  fetch_cfg_pkg::fetch_out_t fetch;
  logic arvalid;
  axi_rd_pkg::ar_chan_t ar;
  logic arready;
  logic rvalid;
  axi_rd_pkg::r_chan_t r;
  logic rready;
  int line_reads;
  int word_reads;

  logic [15:0] lfsr;
  logic table_ready;
  string names [row_count];
  row_t rows [row_count];

  fetch_top uut (
    .clock          (clock),
    .reset          (reset),
    .commit         (commit),
    .clear_pipeline (clear_pipeline),
    .clear_cache    (clear_cache),
    .idu_ready      (idu_ready),
    .block          (block),
    .inst_valid     (inst_valid),
    .fetch          (fetch),
    .arvalid        (arvalid),
    .ar             (ar),
    .arready        (arready),
    .rvalid         (rvalid),
    .r              (r),
    .rready         (rready)
  );

  tb_mem_slave mem (
    .clock      (clock),
    .reset      (reset),
    .arvalid    (arvalid),
    .ar         (ar),
    .arready    (arready),
    .rvalid     (rvalid),
    .r          (r),
    .rready     (rready),
    .line_reads (line_reads),
    .word_reads (word_reads)
  );

  always #10 clock = ~clock;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  function automatic logic random_bit();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic int total_instructions();
    int total;
    total = 0;
    for (int i = 0; i < row_count; i++) begin
      total += rows[i].count;
    end
    return total;
  endfunction

  task automatic report_failure(input string what);
    $display("TESTS FAILED");
    $fatal(1, "%s", what);
  endtask

  task automatic check_fetch(input string name, input fetch_cfg_pkg::fetch_out_t expected,
                             input fetch_cfg_pkg::fetch_out_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected pc %h inst %h, actual pc %h inst %h", name,
               expected.pc, expected.inst, actual.pc, actual.inst);
      report_failure("fetch output did not match");
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      report_failure("read count did not match");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      report_failure("control bit did not match");
    end
  endtask

  task automatic set_row(input int i, input string name, input logic [31:0] target,
                         input int count, input logic random_stall, input logic flush,
                         input int reads);
    names[i] = name;
    rows[i].target = target;
    rows[i].count = count;
    rows[i].random_stall = random_stall;
    rows[i].flush = flush;
    rows[i].reads = reads;
  endtask

  task automatic fill_table();
    set_row(0, "reset_cold", 32'h3000_0000, 8, 1'b0, 1'b0, 2);
    set_row(1, "hit_redirect", 32'h3000_0008, 4, 1'b0, 1'b0, 0);
    set_row(2, "new_line", 32'h3000_0020, 4, 1'b0, 1'b0, 1);
    set_row(3, "clear_refetch", 32'h3000_0000, 8, 1'b0, 1'b1, 2);
    set_row(4, "uncached", 32'h0f00_0100, 3, 1'b0, 1'b0, 3);
    set_row(5, "uncached_repeat", 32'h0f00_0100, 3, 1'b0, 1'b0, 3);
    set_row(6, "stall_cold", 32'h3000_0040, 12, 1'b1, 1'b0, 3);
    set_row(7, "stall_hits", 32'h3000_0044, 6, 1'b1, 1'b0, 0);
    set_row(8, "stall_uncached", 32'h0f00_0200, 4, 1'b1, 1'b0, 4);
    set_row(9, "stall_evict", 32'h3000_0000, 8, 1'b1, 1'b0, 2);
  endtask

  task automatic drive_idle();
    commit = '0;
    clear_pipeline = 1'b0;
    clear_cache = 1'b0;
    idu_ready = 1'b0;
    block = 1'b0;
  endtask

  // execute confirms the fall-through pc of the word just taken
  task automatic drive_commit(input logic valid, input logic [31:0] pc);
    commit = '0;
    if (valid) begin
      commit.npc_valid = 1'b1;
      commit.npc = pc + 32'd4;
      commit.snpc = pc + 32'd4;
    end
  endtask

  // ------------------------------------------------------------------
  // one table row driven on falling edges
  // ------------------------------------------------------------------

  task automatic run_row(input int i);
    row_t row;
    string name;
    int taken;
    int lines_before;
    int words_before;
    int expect_lines;
    int expect_words;
    logic [31:0] expect_pc;
    logic [31:0] last_pc;
    logic took;
    logic held_valid;
    fetch_cfg_pkg::fetch_out_t held;
    fetch_cfg_pkg::fetch_out_t expected;

    row = rows[i];
    name = names[i];
    lines_before = line_reads;
    words_before = word_reads;
    if (row.flush) begin
      clear_cache = 1'b1;
      @(negedge clock);
      clear_cache = 1'b0;
    end
    // the first row runs from the reset pc
    if (i != 0) begin
      clear_pipeline = 1'b1;
      commit.npc = row.target;
      @(negedge clock);
      clear_pipeline = 1'b0;
      commit = '0;
      check_bit({name, " redirect"}, 1'b0, inst_valid);
    end

    taken = 0;
    expect_pc = row.target;
    last_pc = '0;
    took = 1'b0;
    held_valid = 1'b0;
    while (taken < row.count) begin
      if (held_valid) begin
        check_bit({name, " stall"}, 1'b1, inst_valid);
        check_fetch({name, " stall"}, held, fetch);
      end
      drive_commit(took, last_pc);
      if (row.random_stall) begin
        idu_ready = random_bit() | random_bit();
        block = random_bit() & random_bit();
      end else begin
        idu_ready = 1'b1;
        block = 1'b0;
      end
      took = inst_valid && idu_ready && !block;
      held_valid = inst_valid && !took;
      held = fetch;
      if (took) begin
        expected.pc = expect_pc;
        expected.inst = expect_pc ^ mem_key;
        check_fetch(name, expected, fetch);
        last_pc = expect_pc;
        expect_pc = expect_pc + 32'd4;
        taken++;
      end
      @(negedge clock);
    end

    drive_commit(took, last_pc);
    idu_ready = 1'b0;
    block = 1'b0;
    @(negedge clock);
    commit = '0;
    @(negedge clock);

    // no refill may be left running once decode stops taking words
    check_bit({name, " arvalid idle"}, 1'b0, arvalid);
    check_bit({name, " rready idle"}, 1'b0, rready);
    if (row.target[31:24] == fetch_cfg_pkg::uncached_top) begin
      expect_lines = 0;
      expect_words = row.reads;
    end else begin
      expect_lines = row.reads;
      expect_words = 0;
    end
    check_count({name, " line reads"}, expect_lines, line_reads - lines_before);
    check_count({name, " word reads"}, expect_words, word_reads - words_before);
  endtask

  // ------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    table_ready = 1'b0;
    lfsr = 16'd38;
    drive_idle();
    fill_table();
    table_ready = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    check_bit("reset inst_valid", 1'b0, inst_valid);
    check_bit("reset arvalid", 1'b0, arvalid);
    check_bit("reset rready", 1'b0, rready);
    for (int i = 0; i < row_count; i++) begin
      run_row(i);
    end
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    int cycles;
    int limit;
    cycles = 0;
    wait (table_ready === 1'b1);
    limit = 64 * total_instructions() + 200;
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    report_failure("timeout: the fetch runs did not finish within the cycle limit");
  end

endmodule

//--- fetch_top.f
fetch_cfg_pkg.sv
axi_rd_pkg.sv
icache_store.sv
line_refill.sv
fetch_ctrl.sv
fetch_top.sv
tb_mem_slave.sv
tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - fetch_cfg_pkg.sv
  - axi_rd_pkg.sv
  - icache_store.sv
  - line_refill.sv
  - fetch_ctrl.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_mem_slave.sv
      - tb_fetch_top.sv
